// File: stream_bridge_pkg.sv
// ##############################
// stream bridge package
// widths, payload types, APB register map and the
// APB request and response structs
// ##############################

package stream_bridge_pkg;

    // ##############################
    // stream widths
    localparam int IN_WIDTH   = 32;   // input stream
    localparam int MID_WIDTH  = 128;  // packed word
    localparam int OUT_WIDTH  = 16;   // output stream
    localparam int FIFO_DEPTH = 4;    // both FIFOs

    typedef logic [IN_WIDTH-1:0]  in_word_t;
    typedef logic [MID_WIDTH-1:0] mid_word_t;

    // ##############################
    // APB register port
    localparam int APB_ADDR_WIDTH = 8;
    localparam int APB_DATA_WIDTH = 32;

    localparam logic [APB_ADDR_WIDTH-1:0] REG_CTRL      = 8'h00;  // bit 0 enable
    localparam logic [APB_ADDR_WIDTH-1:0] REG_IN_COUNT  = 8'h04;  // accepted input beats
    localparam logic [APB_ADDR_WIDTH-1:0] REG_OUT_COUNT = 8'h08;  // delivered output beats

    typedef struct packed {
        logic                      psel;
        logic                      penable;
        logic                      pwrite;
        logic [APB_ADDR_WIDTH-1:0] paddr;
        logic [APB_DATA_WIDTH-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic                      pready;
        logic                      pslverr;
        logic [APB_DATA_WIDTH-1:0] prdata;
    } apb_rsp_t;

endpackage

// File: axis_if.sv
// ##############################
// valid/ready stream interface
// clock and reset travel with the bus
// ##############################

`timescale 1ns/1ps

interface axis_if #(
    parameter int DATA_WIDTH = 32
) (
    input logic clk_i,
    input logic rst_i
);

    logic                  tvalid;
    logic                  tready;
    logic [DATA_WIDTH-1:0] tdata;

    modport master (
        input  clk_i,
        input  rst_i,
        output tvalid,
        output tdata,
        input  tready
    );

    modport slave (
        input  clk_i,
        input  rst_i,
        input  tvalid,
        input  tdata,
        output tready
    );

endinterface

// File: axis_dw_conv.sv
// ##############################
// stream width converter
// narrows a wide word into slices, low slice first,
// or packs narrow words into a wide one, first word lowest
// ##############################

`timescale 1ns/1ps

module axis_dw_conv #(
    parameter int DATA_WIDTH_IN  = 32,
    parameter int DATA_WIDTH_OUT = 128
) (
    axis_if.master m_axis,
    axis_if.slave  s_axis
);

    logic clk;
    logic rst;
    logic s_fire;
    logic m_fire;

    assign clk    = s_axis.clk_i;
    assign rst    = s_axis.rst_i;
    assign s_fire = s_axis.tvalid & s_axis.tready;
    assign m_fire = m_axis.tvalid & m_axis.tready;

    if (DATA_WIDTH_IN > DATA_WIDTH_OUT) begin : g_down_size
        localparam int RATIO = DATA_WIDTH_IN / DATA_WIDTH_OUT;
        localparam int CNT_W = $clog2(RATIO);

        logic [CNT_W-1:0]                     slice_idx;
        logic                                 last_slice;
        logic                                 busy;
        logic [RATIO-1:0][DATA_WIDTH_OUT-1:0] word_q;  // captured wide word

        assign last_slice = (slice_idx == CNT_W'(RATIO - 1));

        always_ff @(posedge clk) begin
            if (rst) begin
                slice_idx <= '0;
            end else if (m_fire) begin
                slice_idx <= last_slice ? '0 : slice_idx + 1'b1;
            end
        end

        // busy from capture until the last slice leaves
        always_ff @(posedge clk) begin
            if (rst) begin
                busy <= 1'b0;
            end else if (s_fire) begin
                busy <= 1'b1;
            end else if (m_fire && last_slice) begin
                busy <= 1'b0;
            end
        end

        always_ff @(posedge clk) begin
            if (s_fire) begin
                word_q <= s_axis.tdata;
            end
        end

        assign m_axis.tvalid = busy;
        assign m_axis.tdata  = word_q[slice_idx];
        assign s_axis.tready = ~busy;  // accept only when idle

    end else if (DATA_WIDTH_IN < DATA_WIDTH_OUT) begin : g_up_size
        localparam int RATIO = DATA_WIDTH_OUT / DATA_WIDTH_IN;
        localparam int CNT_W = $clog2(RATIO);

        logic [CNT_W-1:0]                    slot_idx;
        logic                                last_slot;
        logic                                out_valid;
        logic [RATIO-1:0][DATA_WIDTH_IN-1:0] pack_q;

        assign last_slot = (slot_idx == CNT_W'(RATIO - 1));

        always_ff @(posedge clk) begin
            if (rst) begin
                slot_idx <= '0;
            end else if (s_fire) begin
                slot_idx <= last_slot ? '0 : slot_idx + 1'b1;
            end
        end

        // valid one cycle after the last slot is filled
        always_ff @(posedge clk) begin
            if (rst) begin
                out_valid <= 1'b0;
            end else if (s_fire && last_slot) begin
                out_valid <= 1'b1;
            end else if (m_fire) begin
                out_valid <= 1'b0;
            end
        end

        always_ff @(posedge clk) begin
            if (s_fire) begin
                pack_q[slot_idx] <= s_axis.tdata;
            end
        end

        assign m_axis.tvalid = out_valid;
        assign m_axis.tdata  = pack_q;
        assign s_axis.tready = m_axis.tready;  // stall input while output is blocked

    end else begin : g_bypass
        assign m_axis.tvalid = s_axis.tvalid;
        assign m_axis.tdata  = s_axis.tdata;
        assign s_axis.tready = m_axis.tready;
    end

endmodule

// File: stream_fifo.sv
// ##############################
// synchronous valid/ready FIFO
// circular buffer, payload type set by parameter
// ##############################

`timescale 1ns/1ps

module stream_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     in_valid_i,
    input  payload_t in_data_i,
    output logic     in_ready_o,
    output logic     out_valid_o,
    output payload_t out_data_o,
    input  logic     out_ready_i
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;  // occupancy
    logic             push;
    logic             pop;

    assign in_ready_o  = (count != CNT_W'(DEPTH));
    assign out_valid_o = (count != '0);
    assign out_data_o  = mem[rd_ptr];

    assign push = in_valid_i & in_ready_o;
    assign pop  = out_valid_o & out_ready_i;

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= in_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: bridge_ctrl.sv
// ##############################
// bridge control block
// APB registers, input admission gate and beat counters
// ##############################

`timescale 1ns/1ps

module bridge_ctrl
    import stream_bridge_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  apb_req_t apb_req_i,
    output apb_rsp_t apb_rsp_o,
    input  logic     s_tvalid_i,
    output logic     s_tready_o,
    output logic     fwd_valid_o,
    input  logic     fwd_ready_i,
    input  logic     out_fire_i
);

    logic                      enable;
    logic [APB_DATA_WIDTH-1:0] in_count;
    logic [APB_DATA_WIDTH-1:0] out_count;
    logic                      access;
    logic                      wr_en;
    logic                      hit_ctrl;
    logic                      hit_in;
    logic                      hit_out;
    logic                      in_fire;

    // ##############################
    // admission gate
    assign fwd_valid_o = s_tvalid_i & enable;
    assign s_tready_o  = fwd_ready_i & enable;
    assign in_fire     = s_tvalid_i & s_tready_o;

    // ##############################
    // APB decode
    assign access   = apb_req_i.psel & apb_req_i.penable;
    assign wr_en    = access & apb_req_i.pwrite;
    assign hit_ctrl = (apb_req_i.paddr == REG_CTRL);
    assign hit_in   = (apb_req_i.paddr == REG_IN_COUNT);
    assign hit_out  = (apb_req_i.paddr == REG_OUT_COUNT);

    always_comb begin
        apb_rsp_o.pready  = access;  // no wait states
        apb_rsp_o.pslverr = access & ~(hit_ctrl | hit_in | hit_out);
        apb_rsp_o.prdata  = '0;
        if (access) begin
            if (hit_ctrl) begin
                apb_rsp_o.prdata = {{(APB_DATA_WIDTH-1){1'b0}}, enable};
            end else if (hit_in) begin
                apb_rsp_o.prdata = in_count;
            end else if (hit_out) begin
                apb_rsp_o.prdata = out_count;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            enable <= 1'b0;
        end else if (wr_en && hit_ctrl) begin
            enable <= apb_req_i.pwdata[0];
        end
    end

    // ##############################
    // beat counters, a write clears
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            in_count <= '0;
        end else if (wr_en && hit_in) begin
            in_count <= '0;
        end else if (in_fire) begin
            in_count <= in_count + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            out_count <= '0;
        end else if (wr_en && hit_out) begin
            out_count <= '0;
        end else if (out_fire_i) begin
            out_count <= out_count + 1'b1;
        end
    end

endmodule

// File: stream_bridge.sv
// ##############################
// stream width bridge top level
// 32-bit in, packed to 128 bits, 16-bit out
// ##############################

`timescale 1ns/1ps

module stream_bridge
    import stream_bridge_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  apb_req_t             apb_req_i,
    output apb_rsp_t             apb_rsp_o,
    input  logic                 s_tvalid_i,
    input  in_word_t             s_tdata_i,
    output logic                 s_tready_o,
    output logic                 m_tvalid_o,
    output logic [OUT_WIDTH-1:0] m_tdata_o,
    input  logic                 m_tready_i
);

    logic fwd_valid;
    logic fwd_ready;
    logic out_fire;

    axis_if #(.DATA_WIDTH(IN_WIDTH))  in_if      (.clk_i(clk_i), .rst_i(rst_i));
    axis_if #(.DATA_WIDTH(MID_WIDTH)) mid_if     (.clk_i(clk_i), .rst_i(rst_i));
    axis_if #(.DATA_WIDTH(MID_WIDTH)) mid_out_if (.clk_i(clk_i), .rst_i(rst_i));
    axis_if #(.DATA_WIDTH(OUT_WIDTH)) out_if     (.clk_i(clk_i), .rst_i(rst_i));

    bridge_ctrl u_ctrl (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .apb_req_i  (apb_req_i),
        .apb_rsp_o  (apb_rsp_o),
        .s_tvalid_i (s_tvalid_i),
        .s_tready_o (s_tready_o),
        .fwd_valid_o(fwd_valid),
        .fwd_ready_i(fwd_ready),
        .out_fire_i (out_fire)
    );

    stream_fifo #(.payload_t(in_word_t), .DEPTH(FIFO_DEPTH)) u_in_fifo (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .in_valid_i (fwd_valid),
        .in_data_i  (s_tdata_i),
        .in_ready_o (fwd_ready),
        .out_valid_o(in_if.tvalid),
        .out_data_o (in_if.tdata),
        .out_ready_i(in_if.tready)
    );

    axis_dw_conv #(.DATA_WIDTH_IN(IN_WIDTH), .DATA_WIDTH_OUT(MID_WIDTH)) u_upsize (
        .m_axis(mid_if),
        .s_axis(in_if)
    );

    stream_fifo #(.payload_t(mid_word_t), .DEPTH(FIFO_DEPTH)) u_mid_fifo (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .in_valid_i (mid_if.tvalid),
        .in_data_i  (mid_if.tdata),
        .in_ready_o (mid_if.tready),
        .out_valid_o(mid_out_if.tvalid),
        .out_data_o (mid_out_if.tdata),
        .out_ready_i(mid_out_if.tready)
    );

    axis_dw_conv #(.DATA_WIDTH_IN(MID_WIDTH), .DATA_WIDTH_OUT(OUT_WIDTH)) u_downsize (
        .m_axis(out_if),
        .s_axis(mid_out_if)
    );

    // output ports
    assign m_tvalid_o    = out_if.tvalid;
    assign m_tdata_o     = out_if.tdata;
    assign out_if.tready = m_tready_i;
    assign out_fire      = out_if.tvalid & out_if.tready;  // delivered beat

endmodule

// File: tb_clk_gen.sv
// ##############################
// testbench clock and reset
// ##############################

`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;  // released on a rising edge
    end

endmodule

// File: stream_bridge_assert.sv
// ##############################
// stream bridge assertions
// handshake stability, reset state, APB pready
// ##############################

`timescale 1ns/1ps

module stream_bridge_assert
    import stream_bridge_pkg::*;
(
    input logic                 clk_i,
    input logic                 rst_i,
    input apb_req_t             apb_req_i,
    input apb_rsp_t             apb_rsp_o,
    input logic                 s_tvalid_i,
    input in_word_t             s_tdata_i,
    input logic                 s_tready_o,
    input logic                 m_tvalid_o,
    input logic [OUT_WIDTH-1:0] m_tdata_o,
    input logic                 m_tready_i
);

    int violations = 0;  // failed assertions so far

    a_in_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        s_tvalid_i && !s_tready_o |=> s_tvalid_i && $stable(s_tdata_i))
    else begin
        violations++;
        $error("input beat changed while stalled");
    end

    a_out_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        m_tvalid_o && !m_tready_i |=> m_tvalid_o && $stable(m_tdata_o))
    else begin
        violations++;
        $error("output beat changed while stalled");
    end

    a_reset_state: assert property (@(posedge clk_i)
        rst_i |=> !m_tvalid_o && !s_tready_o)
    else begin
        violations++;
        $error("stream handshake active right after reset");
    end

    a_pready: assert property (@(posedge clk_i) disable iff (rst_i)
        apb_req_i.psel && apb_req_i.penable |-> apb_rsp_o.pready)
    else begin
        violations++;
        $error("pready low in an APB access phase");
    end

endmodule

// File: tb_stream_bridge.sv
// ##############################
// stream bridge testbench
// runs the command lines of the stimulus file, checks
// APB reads and the order of the output halfwords
// ##############################

`timescale 1ns/1ps

module tb_stream_bridge
    import stream_bridge_pkg::*;
();

    localparam string STIM_FILE      = "stream_bridge_stimulus.txt";
    localparam int    CYCLES_PER_CMD = 20;
    localparam int    TIMEOUT_MARGIN = 100;

    logic                 clk;
    logic                 rst;
    apb_req_t             apb_req;
    apb_rsp_t             apb_rsp;
    logic                 s_tvalid;
    in_word_t             s_tdata;
    logic                 s_tready;
    logic                 m_tvalid;
    logic [OUT_WIDTH-1:0] m_tdata;
    logic                 m_tready;

    integer               seed = 32'hde296676;
    integer               rnd;
    logic [OUT_WIDTH-1:0] expect_q[$];  // halfwords still owed by the DUT
    logic                 enable_model;
    logic                 expect_err;   // set by X for the next access
    int                   cycles;
    int                   cycle_limit;

    tb_clk_gen #(.PERIOD_NS(20), .RESET_CYCLES(10)) u_clk_gen (.clk_o(clk), .rst_o(rst));

    stream_bridge DUT (
        .clk_i     (clk),
        .rst_i     (rst),
        .apb_req_i (apb_req),
        .apb_rsp_o (apb_rsp),
        .s_tvalid_i(s_tvalid),
        .s_tdata_i (s_tdata),
        .s_tready_o(s_tready),
        .m_tvalid_o(m_tvalid),
        .m_tdata_o (m_tdata),
        .m_tready_i(m_tready)
    );

    bind stream_bridge stream_bridge_assert u_assert (.*);

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, actual, expected));
        end
    endtask

    // setup phase, access phase, then back to idle
    task automatic apb_access(input logic write, input logic [7:0] addr, input logic [31:0] data);
        apb_req_t req;
        logic     err_expected;
        err_expected = expect_err;
        expect_err   = 1'b0;
        req          = '0;
        req.psel     = 1'b1;
        req.pwrite   = write;
        req.paddr    = addr;
        req.pwdata   = write ? data : '0;
        @(posedge clk);
        apb_req <= req;
        req.penable = 1'b1;
        @(posedge clk);
        apb_req <= req;
        @(negedge clk);
        check_value("apb_rsp_o.pready", apb_rsp.pready, 32'h1);
        check_value("apb_rsp_o.pslverr", apb_rsp.pslverr, err_expected);
        if (!write && !err_expected) begin
            check_value("apb_rsp_o.prdata", apb_rsp.prdata, data);
        end
        @(posedge clk);
        apb_req <= '0;
        if (write && !err_expected && addr == REG_CTRL) begin
            enable_model = data[0];  // takes effect on this edge
        end
    endtask

    task automatic send_word(input in_word_t data);
        @(posedge clk);
        s_tvalid <= 1'b1;
        s_tdata  <= data;
        expect_q.push_back(data[OUT_WIDTH-1:0]);         // low half first
        expect_q.push_back(data[IN_WIDTH-1:OUT_WIDTH]);
        do begin
            @(negedge clk);
        end while (!s_tready);
        @(posedge clk);
        s_tvalid <= 1'b0;
    endtask

    task automatic drain_output();
        while (expect_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    always @(posedge clk) begin
        rnd = $random(seed);
        m_tready <= rnd[0];
    end

    // ##############################
    // sampled mid-cycle, the transfer happens on the next rising edge
    always @(negedge clk) begin
        if (DUT.u_assert.violations != 0) begin
            abort_run("an assertion in the bound checker failed");
        end
        if (!rst) begin
            if (!enable_model) begin
                check_value("s_tready_o", s_tready, 32'h0);
            end
            if (m_tvalid && m_tready) begin
                if (expect_q.size() == 0) begin
                    abort_run("an output beat arrived with no input word queued");
                end else begin
                    check_value("m_tdata_o", m_tdata, expect_q.pop_front());
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            abort_run($sformatf("timeout after %0d cycles", cycles));
        end
    end

    initial begin
        int          fd;
        int          lines;
        string       cmd;
        string       text;
        logic [31:0] addr;
        logic [31:0] value;
        apb_req      = '0;
        s_tvalid     = 1'b0;
        s_tdata      = '0;
        m_tready     = 1'b0;
        enable_model = 1'b0;
        expect_err   = 1'b0;
        cycles       = 0;
        cycle_limit  = 0;
        lines        = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            abort_run("the stimulus file could not be opened");
        end
        while ($fgets(text, fd) != 0) begin
            if (text.len() > 1 && text.getc(0) != "#") begin
                lines++;
            end
        end
        $fclose(fd);
        cycle_limit = CYCLES_PER_CMD * lines + TIMEOUT_MARGIN;
        fd = $fopen(STIM_FILE, "r");
        wait (rst === 1'b0);
        while ($fscanf(fd, "%s", cmd) == 1) begin
            case (cmd)
                "W": begin
                    void'($fscanf(fd, "%h %h", addr, value));
                    apb_access(1'b1, addr[7:0], value);
                end
                "R": begin
                    void'($fscanf(fd, "%h %h", addr, value));
                    apb_access(1'b0, addr[7:0], value);
                end
                "S": begin
                    void'($fscanf(fd, "%h", value));
                    send_word(value);
                end
                "X": expect_err = 1'b1;
                "D": drain_output();
                default: begin
                    if (cmd.getc(0) == "#") begin
                        void'($fgets(text, fd));
                    end else begin
                        abort_run({"unknown command in the stimulus file: ", cmd});
                    end
                end
            endcase
        end
        $fclose(fd);
        repeat (4) @(posedge clk);
        if (DUT.u_assert.violations == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: stream_bridge_stimulus.txt
# W addr data | R addr expected | S word | X next access errors | D drain
# all numbers in hex
R 00 00000000
R 04 00000000
R 08 00000000
X
R 20 00000000
X
W 0c 00000001
R 00 00000000
W 00 00000001
S 11112222
S 33334444
S 55556666
R 08 00000000
R 04 00000003
S 77778888
D
R 04 00000004
R 08 00000008
S a001b002
S a003b004
S a005b006
S a007b008
S c009d00a
S c00bd00c
S c00dd00e
S c00fd010
S e011f012
S e013f014
S e015f016
S e017f018
D
R 04 00000010
R 08 00000020
W 04 00000000
W 08 00000000
R 04 00000000
R 08 00000000
S 0badcafe
S 12345678
S 9abcdef0
S 0f1e2d3c
W 00 00000000
D
R 00 00000000
R 04 00000004
R 08 00000008

// File: stream_bridge.f
stream_bridge_pkg.sv
axis_if.sv
axis_dw_conv.sv
stream_fifo.sv
bridge_ctrl.sv
stream_bridge.sv
tb_clk_gen.sv
stream_bridge_assert.sv
tb_stream_bridge.sv
